// ==== Makefile ====
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: obj_dir/Vfetch_tb
	@out=$$(./obj_dir/Vfetch_tb); echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

obj_dir/Vfetch_tb: files.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module fetch_tb -o Vfetch_tb

clean:
	rm -rf obj_dir

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Privilege levels
  ////////////////////////////////////////////////////////////

  // Encoding follows the RISC-V mstatus.MPP field
  // Supervisor and hypervisor levels are not supported here
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // addi x0, x0, 0
  // Writes to x0 are discarded, so the dummy has no architectural effect
  localparam logic [31:0] DUMMY_INSTR = 32'h0000_0013;

  ////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////

  // First fetch address after reset, word aligned
  localparam logic [31:0] RESET_PC = 32'h0000_0080;

endpackage

// ==== design/fetch_top.sv ====
module fetch_top #(
  parameter int          FIFO_DEPTH = 4,
  parameter logic [15:0] LFSR_SEED  = 16'hACE1
) (
  input  logic                clk,
  input  logic                rst_n,

  // Wishbone classic master
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [31:0]         wb_adr_o,
  input  logic [31:0]         wb_dat_i,
  input  logic                wb_ack_i,

  // Controller
  input  logic                halt_if_i,
  input  logic                kill_if_i,
  input  logic                pc_set_i,
  input  logic [31:0]         pc_target_i,
  input  fetch_pkg::privlvl_t priv_lvl_i,
  input  logic                dummy_en_i,

  // Decode side
  output logic                if_valid_o,
  output logic [31:0]         instr_o,
  output logic [31:0]         pc_o,
  output fetch_pkg::privlvl_t priv_lvl_o,
  output logic                dummy_o,
  input  logic                id_ready_i
);

  localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

  // Flush of prefetcher, FIFO and output register
  logic                flush;

  // Prefetcher to FIFO
  logic                push;
  logic [31:0]         push_instr;
  logic [31:0]         push_addr;
  fetch_pkg::privlvl_t push_priv;
  logic [LEVEL_W-1:0]  fifo_level;

  // FIFO to fetch stage
  logic                fifo_valid;
  logic [31:0]         fifo_instr;
  logic [31:0]         fifo_addr;
  fetch_pkg::privlvl_t fifo_priv;
  logic                pop;

  // A new PC always discards what was fetched on the old path
  assign flush = kill_if_i | pc_set_i;

  ////////////////////////////////////////////////////////////
  // Prefetcher
  ////////////////////////////////////////////////////////////

  prefetch_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .kill_i       (flush),
    .pc_set_i     (pc_set_i),
    .pc_target_i  (pc_target_i),
    .priv_lvl_i   (priv_lvl_i),
    .fifo_level_i (fifo_level),
    .push_o       (push),
    .push_instr_o (push_instr),
    .push_addr_o  (push_addr),
    .push_priv_o  (push_priv)
  );

  prefetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .push_i       (push),
    .push_instr_i (push_instr),
    .push_addr_i  (push_addr),
    .push_priv_i  (push_priv),
    .pop_i        (pop),
    .valid_o      (fifo_valid),
    .instr_o      (fifo_instr),
    .addr_o       (fifo_addr),
    .priv_o       (fifo_priv),
    .level_o      (fifo_level)
  );

  ////////////////////////////////////////////////////////////
  // Fetch stage
  ////////////////////////////////////////////////////////////

  if_stage #(
    .LFSR_SEED (LFSR_SEED)
  ) u_if_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .halt_i       (halt_if_i),
    .kill_i       (flush),
    .dummy_en_i   (dummy_en_i),
    .id_ready_i   (id_ready_i),
    .fifo_valid_i (fifo_valid),
    .fifo_instr_i (fifo_instr),
    .fifo_addr_i  (fifo_addr),
    .fifo_priv_i  (fifo_priv),
    .pop_o        (pop),
    .if_valid_o   (if_valid_o),
    .instr_o      (instr_o),
    .pc_o         (pc_o),
    .priv_lvl_o   (priv_lvl_o),
    .dummy_o      (dummy_o)
  );

endmodule

// ==== design/if_stage/if_stage.sv ====
module if_stage #(
  parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
  input  logic                clk,
  input  logic                rst_n,

  // Controller
  input  logic                halt_i,
  input  logic                kill_i,
  input  logic                dummy_en_i,

  // Decode handshake
  input  logic                id_ready_i,

  // Prefetch FIFO head
  input  logic                fifo_valid_i,
  input  logic [31:0]         fifo_instr_i,
  input  logic [31:0]         fifo_addr_i,
  input  fetch_pkg::privlvl_t fifo_priv_i,
  output logic                pop_o,

  // Toward decode
  output logic                if_valid_o,
  output logic [31:0]         instr_o,
  output logic [31:0]         pc_o,
  output fetch_pkg::privlvl_t priv_lvl_o,
  output logic                dummy_o
);

  // Output register
  logic                valid_q;
  logic                dummy_q;
  logic [31:0]         instr_q;
  logic [31:0]         pc_q;
  fetch_pkg::privlvl_t priv_q;

  // Remembers whether the last loaded entry was a dummy
  logic                last_dummy_q;

  logic [15:0]         lfsr_q;
  logic                lfsr_fb;

  logic                accept;
  logic                reg_free;
  logic                load;
  logic                insert_dummy;

  ////////////////////////////////////////////////////////////
  // Handshake and load decision
  ////////////////////////////////////////////////////////////

  // Halt and kill both hide the held entry from decode
  assign if_valid_o = valid_q & ~halt_i & ~kill_i;
  assign accept     = if_valid_o & id_ready_i;

  // Register can take a new entry when empty or being consumed
  assign reg_free = ~valid_q | accept;
  assign load     = reg_free & fifo_valid_i & ~halt_i & ~kill_i;

  // Never two dummies in a row, and only with a real entry waiting
  assign insert_dummy = dummy_en_i & lfsr_q[0] & ~last_dummy_q;

  // A dummy leaves the FIFO head in place
  assign pop_o = load & ~insert_dummy;

  ////////////////////////////////////////////////////////////
  // Dummy insertion LFSR
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (accept) begin
      // One step per instruction taken by decode
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= 1'b0;
      dummy_q      <= 1'b0;
      last_dummy_q <= 1'b0;
    end else if (kill_i) begin
      // Everything in flight is discarded
      valid_q      <= 1'b0;
      dummy_q      <= 1'b0;
      last_dummy_q <= 1'b0;
    end else if (load) begin
      valid_q      <= 1'b1;
      dummy_q      <= insert_dummy;
      last_dummy_q <= insert_dummy;
    end else if (accept) begin
      // Taken with nothing behind it
      valid_q <= 1'b0;
      dummy_q <= 1'b0;
    end
  end

  // Payload, dummy copies address and privilege of the FIFO head
  always_ff @(posedge clk) begin
    if (load) begin
      instr_q <= insert_dummy ? fetch_pkg::DUMMY_INSTR : fifo_instr_i;
      pc_q    <= fifo_addr_i;
      priv_q  <= fifo_priv_i;
    end
  end

  assign instr_o    = instr_q;
  assign pc_o       = pc_q;
  assign priv_lvl_o = priv_q;
  assign dummy_o    = dummy_q;

endmodule

// ==== design/prefetch/prefetch_ctrl.sv ====
module prefetch_ctrl #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // Wishbone classic master, read only
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [31:0]                 wb_adr_o,
  input  logic [31:0]                 wb_dat_i,
  input  logic                        wb_ack_i,

  // Flush and redirect
  input  logic                        kill_i,
  input  logic                        pc_set_i,
  input  logic [31:0]                 pc_target_i,
  input  fetch_pkg::privlvl_t         priv_lvl_i,

  // FIFO side
  input  logic [$clog2(FIFO_DEPTH):0] fifo_level_i,
  output logic                        push_o,
  output logic [31:0]                 push_instr_o,
  output logic [31:0]                 push_addr_o,
  output fetch_pkg::privlvl_t         push_priv_o
);

  localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

  logic                busy_q;
  logic                stale_q;
  logic [31:0]         adr_q;
  logic [31:0]         next_pc_q;
  fetch_pkg::privlvl_t cur_priv_q;
  fetch_pkg::privlvl_t req_priv_q;

  logic [LEVEL_W-1:0]  free_cnt;
  logic                outstanding;
  logic                credit_ok;
  logic                resp_done;
  logic                resp_good;
  logic                start_req;
  logic [31:0]         start_addr;

  ////////////////////////////////////////////////////////////
  // Credit and request decisions
  ////////////////////////////////////////////////////////////

  // Transfer ends on ack, good only if no flush hit it meanwhile
  assign resp_done = busy_q & wb_ack_i;
  assign resp_good = resp_done & ~stale_q;

  // Free slots minus the response still owed to the FIFO
  assign free_cnt    = LEVEL_W'(FIFO_DEPTH) - fifo_level_i;
  assign outstanding = busy_q & ~stale_q;
  assign credit_ok   = free_cnt > {{(LEVEL_W-1){1'b0}}, outstanding};

  // Next transfer may start on the ack cycle of the current one
  assign start_req  = ~kill_i & (~busy_q | resp_done) & credit_ok;

  // Back to back: continue right after the word just returned
  assign start_addr = resp_good ? adr_q + 32'd4 : next_pc_q;

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      stale_q    <= 1'b0;
      adr_q      <= fetch_pkg::RESET_PC;
      next_pc_q  <= fetch_pkg::RESET_PC;
      cur_priv_q <= fetch_pkg::PRIV_LVL_M;
    end else if (kill_i) begin
      // Open transfer must still run to its ack, data is then dropped
      busy_q  <= busy_q & ~wb_ack_i;
      stale_q <= busy_q & ~wb_ack_i;
      if (pc_set_i) begin
        // Low address bits ignored, fetch is word aligned
        next_pc_q  <= {pc_target_i[31:2], 2'b00};
        cur_priv_q <= priv_lvl_i;
      end
    end else begin
      if (resp_good) begin
        next_pc_q <= adr_q + 32'd4;
      end
      if (resp_done) begin
        busy_q  <= 1'b0;
        stale_q <= 1'b0;
      end
      if (start_req) begin
        busy_q <= 1'b1;
        adr_q  <= start_addr;
      end
    end
  end

  // Privilege is captured when the request starts
  always_ff @(posedge clk) begin
    if (start_req) begin
      req_priv_q <= cur_priv_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // cyc and stb stay high together for the whole transfer
  assign wb_cyc_o = busy_q;
  assign wb_stb_o = busy_q;
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  assign push_o       = resp_good;
  assign push_instr_o = wb_dat_i;
  assign push_addr_o  = adr_q;
  assign push_priv_o  = req_priv_q;

endmodule

// ==== design/prefetch/prefetch_fifo.sv ====
module prefetch_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,

  // Write side
  input  logic                        push_i,
  input  logic [31:0]                 push_instr_i,
  input  logic [31:0]                 push_addr_i,
  input  fetch_pkg::privlvl_t         push_priv_i,

  // Read side, head is shown while valid_o is high
  input  logic                        pop_i,
  output logic                        valid_o,
  output logic [31:0]                 instr_o,
  output logic [31:0]                 addr_o,
  output fetch_pkg::privlvl_t         priv_o,
  output logic [$clog2(FIFO_DEPTH):0] level_o
);

  localparam int PTR_W   = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W = PTR_W + 1;

  // Storage, no reset needed
  logic [31:0]         instr_mem [FIFO_DEPTH];
  logic [31:0]         addr_mem  [FIFO_DEPTH];
  fetch_pkg::privlvl_t priv_mem  [FIFO_DEPTH];

  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [LEVEL_W-1:0]  count_q;
  logic                push_ok;
  logic                pop_ok;

  // Overflow and underflow guarded locally
  assign push_ok = push_i & (count_q != LEVEL_W'(FIFO_DEPTH));
  assign pop_ok  = pop_i & (count_q != '0);

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Flush beats a push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_ok)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + LEVEL_W'(push_ok) - LEVEL_W'(pop_ok);
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      instr_mem[wr_ptr_q] <= push_instr_i;
      addr_mem[wr_ptr_q]  <= push_addr_i;
      priv_mem[wr_ptr_q]  <= push_priv_i;
    end
  end

  assign valid_o = (count_q != '0);
  assign instr_o = instr_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign priv_o  = priv_mem[rd_ptr_q];
  assign level_o = count_q;

endmodule

// ==== files.f ====
common/fetch_pkg.sv
design/prefetch/prefetch_ctrl.sv
design/prefetch/prefetch_fifo.sv
design/if_stage/if_stage.sv
design/fetch_top.sv
tests/wb_instr_mem.sv
tests/if_stage_checker.sv
tests/fetch_tb.sv

// ==== tests/fetch_tb.sv ====
module fetch_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 200;

  logic                clk = 1'b0;
  logic                rst_n;

  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic                wb_we_o;
  logic [31:0]         wb_adr_o;
  logic [31:0]         wb_dat_i;
  logic                wb_ack_i;

  logic                halt_if_i;
  logic                kill_if_i;
  logic                pc_set_i;
  logic [31:0]         pc_target_i;
  fetch_pkg::privlvl_t priv_lvl_i;
  logic                dummy_en_i;

  logic                if_valid_o;
  logic [31:0]         instr_o;
  logic [31:0]         pc_o;
  fetch_pkg::privlvl_t priv_lvl_o;
  logic                dummy_o;
  logic                id_ready_i;

  logic                rule_violation;

  // Stream bookkeeping
  logic [31:0]         exp_pc;
  logic                prev_dummy;
  int                  dummy_count;

  // 40 ns period
  always #20 clk = ~clk;

  fetch_top #(
    .FIFO_DEPTH (4),
    .LFSR_SEED  (16'hACE1)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .halt_if_i   (halt_if_i),
    .kill_if_i   (kill_if_i),
    .pc_set_i    (pc_set_i),
    .pc_target_i (pc_target_i),
    .priv_lvl_i  (priv_lvl_i),
    .dummy_en_i  (dummy_en_i),
    .if_valid_o  (if_valid_o),
    .instr_o     (instr_o),
    .pc_o        (pc_o),
    .priv_lvl_o  (priv_lvl_o),
    .dummy_o     (dummy_o),
    .id_ready_i  (id_ready_i)
  );

  wb_instr_mem mem0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i)
  );

  if_stage_checker chk0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_o),
    .wb_stb_i    (wb_stb_o),
    .wb_we_i     (wb_we_o),
    .wb_adr_i    (wb_adr_o),
    .wb_ack_i    (wb_ack_i),
    .halt_if_i   (halt_if_i),
    .kill_if_i   (kill_if_i),
    .pc_set_i    (pc_set_i),
    .set_priv_i  (priv_lvl_i),
    .if_valid_i  (if_valid_o),
    .instr_i     (instr_o),
    .pc_i        (pc_o),
    .out_priv_i  (priv_lvl_o),
    .dummy_i     (dummy_o),
    .id_ready_i  (id_ready_i),
    .violation_o (rule_violation)
  );

  ////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Checker found a protocol or rule violation
  always @(posedge rule_violation) begin
    abort_run();
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_priv(input string what, input fetch_pkg::privlvl_t got,
                            input fetch_pkg::privlvl_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Memory content rule, word depends on the address alone
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic init_inputs();
    rst_n       <= 1'b0;
    halt_if_i   <= 1'b0;
    kill_if_i   <= 1'b0;
    pc_set_i    <= 1'b0;
    pc_target_i <= '0;
    priv_lvl_i  <= fetch_pkg::PRIV_LVL_M;
    dummy_en_i  <= 1'b0;
    id_ready_i  <= 1'b1;
  endtask

  task automatic reset_dut();
    int cycles;
    cycles = 0;
    repeat (2) @(posedge clk);
    // Values seen here were produced during reset
    check_flag("wb_cyc_o in reset", wb_cyc_o, 1'b0);
    check_flag("wb_stb_o in reset", wb_stb_o, 1'b0);
    check_flag("if_valid_o in reset", if_valid_o, 1'b0);
    check_flag("dummy_o in reset", dummy_o, 1'b0);
    rst_n <= 1'b1;
    while (!wb_cyc_o && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (!wb_cyc_o) begin
      $display("Timeout: no bus cycle started after reset");
      abort_run();
    end
    check_word("first fetch address", wb_adr_o, fetch_pkg::RESET_PC);
    exp_pc     = fetch_pkg::RESET_PC;
    prev_dummy = 1'b0;
  endtask

  // Waits for one handshake with decode, optionally randomizing ready
  task automatic take_next(input logic rand_ready, output logic [31:0] pc,
                           output logic [31:0] instr, output fetch_pkg::privlvl_t priv,
                           output logic dummy);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      if (if_valid_o && id_ready_i) begin
        pc    = pc_o;
        instr = instr_o;
        priv  = priv_lvl_o;
        dummy = dummy_o;
        got   = 1'b1;
      end
      id_ready_i <= rand_ready ? (($urandom & 32'd3) != 32'd0) : 1'b1;
      cycles++;
    end
    if (!got) begin
      $display("Timeout: decode took no instruction within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  endtask

  // Takes count instructions and checks them against the address sequence
  task automatic expect_stream(input int count, input logic rand_ready, input logic dummies_ok,
                               input fetch_pkg::privlvl_t exp_priv);
    logic [31:0]         pc;
    logic [31:0]         instr;
    fetch_pkg::privlvl_t priv;
    logic                dummy;
    for (int i = 0; i < count; i++) begin
      take_next(rand_ready, pc, instr, priv, dummy);
      // Dummy shows the address of the next real entry
      check_word("pc", pc, exp_pc);
      check_priv("privilege", priv, exp_priv);
      if (!dummies_ok) check_flag("dummy flag", dummy, 1'b0);
      if (dummy) begin
        check_word("dummy instruction", instr, fetch_pkg::DUMMY_INSTR);
        check_flag("dummy right after dummy", prev_dummy, 1'b0);
        dummy_count++;
      end else begin
        check_word("instruction", instr, expected_word(pc));
        exp_pc = exp_pc + 32'd4;
      end
      prev_dummy = dummy;
    end
  endtask

  // New PC, with or without kill, held for one cycle
  task automatic redirect(input logic [31:0] target, input fetch_pkg::privlvl_t priv,
                          input logic with_kill);
    kill_if_i   <= with_kill;
    pc_set_i    <= 1'b1;
    pc_target_i <= target;
    priv_lvl_i  <= priv;
    @(posedge clk);
    check_flag("if_valid_o during redirect", if_valid_o, 1'b0);
    kill_if_i  <= 1'b0;
    pc_set_i   <= 1'b0;
    // Fetch restarts at the word that holds the target
    exp_pc     = target & 32'hFFFF_FFFC;
    prev_dummy = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_sequential();
    expect_stream(16, 1'b0, 1'b0, fetch_pkg::PRIV_LVL_M);
  endtask

  task automatic test_back_pressure();
    expect_stream(32, 1'b1, 1'b0, fetch_pkg::PRIV_LVL_M);
  endtask

  task automatic test_kill_new_pc();
    expect_stream(4, 1'b0, 1'b0, fetch_pkg::PRIV_LVL_M);
    redirect(32'h0000_0400, fetch_pkg::PRIV_LVL_M, 1'b1);
    // Old path must not leak, stream restarts at 0x400
    expect_stream(12, 1'b1, 1'b0, fetch_pkg::PRIV_LVL_M);
  endtask

  task automatic test_halt();
    expect_stream(4, 1'b0, 1'b0, fetch_pkg::PRIV_LVL_M);
    halt_if_i <= 1'b1;
    repeat (12) begin
      @(posedge clk);
      check_flag("if_valid_o during halt", if_valid_o, 1'b0);
    end
    halt_if_i <= 1'b0;
    expect_stream(8, 1'b1, 1'b0, fetch_pkg::PRIV_LVL_M);
  endtask

  task automatic test_dummy();
    dummy_en_i  <= 1'b1;
    dummy_count = 0;
    expect_stream(64, 1'b0, 1'b1, fetch_pkg::PRIV_LVL_M);
    check_flag("dummies inserted", dummy_count != 0, 1'b1);
  endtask

  task automatic test_priv_change();
    // Target off the word grid, low bits must not reach the bus
    redirect(32'h0000_0802, fetch_pkg::PRIV_LVL_U, 1'b0);
    // Dummies still enabled here, they must carry U too
    expect_stream(24, 1'b1, 1'b1, fetch_pkg::PRIV_LVL_U);
    dummy_en_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h2172));
    init_inputs();
    reset_dut();
    test_sequential();
    test_back_pressure();
    test_kill_new_pc();
    test_halt();
    test_dummy();
    test_priv_change();
    repeat (4) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== tests/if_stage_checker.sv ====
module if_stage_checker (
  input  logic                clk,
  input  logic                rst_n,

  // Bus side
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [31:0]         wb_adr_i,
  input  logic                wb_ack_i,

  // Controller side
  input  logic                halt_if_i,
  input  logic                kill_if_i,
  input  logic                pc_set_i,
  input  fetch_pkg::privlvl_t set_priv_i,

  // Decode side
  input  logic                if_valid_i,
  input  logic [31:0]         instr_i,
  input  logic [31:0]         pc_i,
  input  fetch_pkg::privlvl_t out_priv_i,
  input  logic                dummy_i,
  input  logic                id_ready_i,

  output logic                violation_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic                flush;
  logic                prev_cyc;
  logic                prev_ack;
  logic [31:0]         prev_adr;
  fetch_pkg::privlvl_t exp_priv;
  logic                last_dummy;

  // Entry shown to decode but not yet taken
  logic                held;
  logic [31:0]         held_instr;
  logic [31:0]         held_pc;
  fetch_pkg::privlvl_t held_priv;
  logic                held_dummy;

  assign flush = kill_if_i | pc_set_i;

  task automatic flag_violation(input string msg);
    $display("Checker at %0t ns: %s", $time, msg);
    violation_o <= 1'b1;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      violation_o <= 1'b0;
      prev_cyc    <= 1'b0;
      prev_ack    <= 1'b0;
      prev_adr    <= '0;
      exp_priv    <= fetch_pkg::PRIV_LVL_M;
      last_dummy  <= 1'b0;
      held        <= 1'b0;
    end else begin
      ////////////////////////////////////////////////////////////
      // Wishbone classic rules
      ////////////////////////////////////////////////////////////
      if (wb_cyc_i != wb_stb_i) flag_violation("bus cyc and stb differ");
      if (wb_cyc_i && wb_we_i) flag_violation("write cycle on the instruction bus");
      if (wb_cyc_i && wb_adr_i[1:0] != 2'b00) flag_violation("bus address is not word aligned");
      // Open transfer must hold until its ack
      if (prev_cyc && !prev_ack && !wb_cyc_i) flag_violation("bus cycle dropped before ack");
      if (prev_cyc && !prev_ack && wb_adr_i != prev_adr) begin
        flag_violation("bus address changed before ack");
      end
      prev_cyc <= wb_cyc_i;
      prev_ack <= wb_ack_i;
      prev_adr <= wb_adr_i;

      ////////////////////////////////////////////////////////////
      // Halt, kill and privilege
      ////////////////////////////////////////////////////////////
      if (if_valid_i && flush) flag_violation("instruction offered during kill or new PC");
      if (if_valid_i && halt_if_i) flag_violation("instruction offered during halt");
      // New privilege applies to everything fetched after the redirect
      if (pc_set_i) exp_priv <= set_priv_i;
      if (if_valid_i && out_priv_i != exp_priv) begin
        flag_violation("instruction carries the wrong privilege level");
      end

      // Dummy rules
      if (if_valid_i && dummy_i && instr_i != fetch_pkg::DUMMY_INSTR) begin
        flag_violation("dummy entry without the dummy encoding");
      end
      if (flush) begin
        last_dummy <= 1'b0;
      end else if (if_valid_i && id_ready_i) begin
        if (dummy_i && last_dummy) flag_violation("two dummy instructions in a row");
        last_dummy <= dummy_i;
      end

      // Untaken entry must reappear unchanged
      if (flush) begin
        held <= 1'b0;
      end else if (if_valid_i) begin
        if (held && (instr_i != held_instr || pc_i != held_pc ||
                     out_priv_i != held_priv || dummy_i != held_dummy)) begin
          flag_violation("output changed before decode took it");
        end
        held       <= !id_ready_i;
        held_instr <= instr_i;
        held_pc    <= pc_i;
        held_priv  <= out_priv_i;
        held_dummy <= dummy_i;
      end
    end
  end

endmodule

// ==== tests/wb_instr_mem.sv ====
module wb_instr_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read-only instruction memory, content is a function of the address
  // Registered ack, one cycle high per transfer
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= 1'b0;
      // Random wait states, about one in three cycles is a stall
      if (wb_cyc_i && wb_stb_i && !wb_we_i && !wb_ack_o &&
          ($urandom_range(2, 0) != 0)) begin
        wb_ack_o <= 1'b1;
        wb_dat_o <= wb_adr_i ^ 32'hA5A5_0000;
      end
    end
  end

endmodule
